//--- hw/ttt_pkg.sv
// wild misere tic-tac-toe
// shared types and codes

package ttt_pkg;

	// board size, squares numbered 1 to 9
	localparam int NUM_SQUARES = 9;

	// one square of the board
	typedef logic [1:0] tile_t;

	// player number, also reused as result code
	typedef logic [1:0] player_t;

	// square select from the switches
	// only 1..9 address a square
	typedef logic [3:0] square_t;

	// one seven-segment digit, active low, bit 6 is segment g
	typedef logic [6:0] seg_t;

	// tile codes
	localparam tile_t TILE_EMPTY = 2'b00;
	localparam tile_t TILE_X = 2'b01;
	localparam tile_t TILE_O = 2'b10;

	// player and result codes
	localparam player_t PLAYER_NONE = 2'b00;
	localparam player_t PLAYER_1 = 2'b01;
	localparam player_t PLAYER_2 = 2'b10;
	// result only, never a turn
	localparam player_t RESULT_TIE = 2'b11;

	// tile glyphs on the digit
	// middle bar only
	localparam seg_t SEG_BLANK_DASH = 7'b0111111;
	// X is drawn as H
	localparam seg_t SEG_TILE_X = 7'b0001001;
	// O is drawn as 0
	localparam seg_t SEG_TILE_O = 7'b1000000;

	// turn sequencing, two commits per move then one check cycle
	typedef enum logic [3:0] {
		P1_SQUARE,
		P1_SQUARE_WAIT,
		P1_TILE,
		P1_TILE_WAIT,
		P1_CHECK,
		P2_SQUARE,
		P2_SQUARE_WAIT,
		P2_TILE,
		P2_TILE_WAIT,
		P2_CHECK,
		P1_LOST,
		P2_LOST,
		TIE
	} game_state_t;

endpackage

//--- hw/turn_control.sv
// turn sequencing FSM
// square commit, tile commit, end check

`timescale 1ns/10ps

module turn_control (
	input  logic               clock,
	input  logic               resetn,
	input  logic               go,
	input  logic               line_made,
	input  logic               board_full,
	output logic               load_square,
	output logic               load_tile,
	output logic               check_done,
	output ttt_pkg::player_t   turn
);

	ttt_pkg::game_state_t state;
	ttt_pkg::game_state_t next_state;

	// next state
	always_comb
	begin
		next_state = state;
		case (state)
			// wait for go to rise on the square
			ttt_pkg::P1_SQUARE:
				next_state = go ? ttt_pkg::P1_SQUARE_WAIT : ttt_pkg::P1_SQUARE;
			// square committed when go drops
			ttt_pkg::P1_SQUARE_WAIT:
				next_state = go ? ttt_pkg::P1_SQUARE_WAIT : ttt_pkg::P1_TILE;
			ttt_pkg::P1_TILE:
				next_state = go ? ttt_pkg::P1_TILE_WAIT : ttt_pkg::P1_TILE;
			// tile committed, board settles on this edge
			ttt_pkg::P1_TILE_WAIT:
				next_state = go ? ttt_pkg::P1_TILE_WAIT : ttt_pkg::P1_CHECK;
			// misere rule, own line loses
			ttt_pkg::P1_CHECK:
			begin
				if (line_made)
					next_state = ttt_pkg::P1_LOST;
				else if (board_full)
					next_state = ttt_pkg::TIE;
				else
					next_state = ttt_pkg::P2_SQUARE;
			end
			ttt_pkg::P2_SQUARE:
				next_state = go ? ttt_pkg::P2_SQUARE_WAIT : ttt_pkg::P2_SQUARE;
			ttt_pkg::P2_SQUARE_WAIT:
				next_state = go ? ttt_pkg::P2_SQUARE_WAIT : ttt_pkg::P2_TILE;
			ttt_pkg::P2_TILE:
				next_state = go ? ttt_pkg::P2_TILE_WAIT : ttt_pkg::P2_TILE;
			ttt_pkg::P2_TILE_WAIT:
				next_state = go ? ttt_pkg::P2_TILE_WAIT : ttt_pkg::P2_CHECK;
			ttt_pkg::P2_CHECK:
			begin
				if (line_made)
					next_state = ttt_pkg::P2_LOST;
				else if (board_full)
					next_state = ttt_pkg::TIE;
				else
					next_state = ttt_pkg::P1_SQUARE;
			end
			// end states hold until reset, go ignored
			ttt_pkg::P1_LOST,
			ttt_pkg::P2_LOST,
			ttt_pkg::TIE:
				next_state = state;
			default:
				next_state = ttt_pkg::P1_SQUARE;
		endcase
	end

	// state register
	always_ff @(posedge clock)
	begin
		if (!resetn)
			state <= ttt_pkg::P1_SQUARE;
		else
			state <= next_state;
	end

	// output decode
	always_comb
	begin
		// idle values, nobody to move
		load_square = 1'b0;
		load_tile = 1'b0;
		check_done = 1'b0;
		turn = ttt_pkg::PLAYER_NONE;
		case (state)
			ttt_pkg::P1_SQUARE,
			ttt_pkg::P1_SQUARE_WAIT:
			begin
				load_square = 1'b1;
				turn = ttt_pkg::PLAYER_1;
			end
			// tile tracks input through the wait state too
			ttt_pkg::P1_TILE,
			ttt_pkg::P1_TILE_WAIT:
			begin
				load_tile = 1'b1;
				turn = ttt_pkg::PLAYER_1;
			end
			// only pulse when this move ends the game
			ttt_pkg::P1_CHECK:
			begin
				check_done = line_made | board_full;
				turn = ttt_pkg::PLAYER_1;
			end
			ttt_pkg::P2_SQUARE,
			ttt_pkg::P2_SQUARE_WAIT:
			begin
				load_square = 1'b1;
				turn = ttt_pkg::PLAYER_2;
			end
			ttt_pkg::P2_TILE,
			ttt_pkg::P2_TILE_WAIT:
			begin
				load_tile = 1'b1;
				turn = ttt_pkg::PLAYER_2;
			end
			ttt_pkg::P2_CHECK:
			begin
				check_done = line_made | board_full;
				turn = ttt_pkg::PLAYER_2;
			end
			default:
			begin
				turn = ttt_pkg::PLAYER_NONE;
			end
		endcase
	end

endmodule

//--- hw/board_store.sv
// board registers
// square latch and nine squares

`timescale 1ns/10ps

module board_store (
	input  logic                                         clock,
	input  logic                                         resetn,
	input  logic                                         load_square,
	input  logic                                         load_tile,
	input  ttt_pkg::square_t                             square,
	input  ttt_pkg::tile_t                               tile,
	output ttt_pkg::tile_t [ttt_pkg::NUM_SQUARES-1:0]    board
);

	// square picked by the current player
	ttt_pkg::square_t sel_square;

	// latch follows the switches while in a square state
	// last value before go drops is the one kept
	always_ff @(posedge clock)
	begin
		if (!resetn)
			sel_square <= '0;
		else if (load_square)
			sel_square <= square;
	end

	// nine square registers
	// board[0] is square 1, board[8] is square 9
	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			for (int i = 0; i < ttt_pkg::NUM_SQUARES; i++)
				board[i] <= ttt_pkg::TILE_EMPTY;
		end
		else if (load_tile)
		begin
			// select 0 or 10..15 matches nothing
			// occupied square just gets overwritten
			for (int i = 0; i < ttt_pkg::NUM_SQUARES; i++)
			begin
				if (sel_square == ttt_pkg::square_t'(i + 1))
					board[i] <= tile;
			end
		end
	end

endmodule

//--- hw/end_check.sv
// end of game detection
// misere lines, full board, result register

`timescale 1ns/10ps

module end_check (
	input  logic                                         clock,
	input  logic                                         resetn,
	input  ttt_pkg::tile_t [ttt_pkg::NUM_SQUARES-1:0]    board,
	input  ttt_pkg::player_t                             turn,
	input  logic                                         check_done,
	output logic                                         line_made,
	output logic                                         board_full,
	output logic                                         game_over,
	output ttt_pkg::player_t                             winner
);

	// one flag per line, rows then columns then diagonals
	logic [7:0] line_hit;

	// three equal tiles, empty never counts
	function automatic logic same3(
		input ttt_pkg::tile_t a,
		input ttt_pkg::tile_t b,
		input ttt_pkg::tile_t c
	);
		return (a != ttt_pkg::TILE_EMPTY) && (a == b) && (b == c);
	endfunction

	// squares 1..9 sit at board[0..8]
	always_comb
	begin
		// rows
		line_hit[0] = same3(board[0], board[1], board[2]);
		line_hit[1] = same3(board[3], board[4], board[5]);
		line_hit[2] = same3(board[6], board[7], board[8]);
		// columns
		line_hit[3] = same3(board[0], board[3], board[6]);
		line_hit[4] = same3(board[1], board[4], board[7]);
		line_hit[5] = same3(board[2], board[5], board[8]);
		// diagonals
		line_hit[6] = same3(board[0], board[4], board[8]);
		line_hit[7] = same3(board[2], board[4], board[6]);
	end

	assign line_made = |line_hit;

	// full when no square is empty
	always_comb
	begin
		board_full = 1'b1;
		for (int i = 0; i < ttt_pkg::NUM_SQUARES; i++)
		begin
			if (board[i] == ttt_pkg::TILE_EMPTY)
				board_full = 1'b0;
		end
	end

	// result captured on the edge that leaves the check state
	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			game_over <= 1'b0;
			winner <= ttt_pkg::PLAYER_NONE;
		end
		else if (check_done)
		begin
			game_over <= 1'b1;
			// mover made the line, so the other player takes it
			if (line_made)
				winner <= (turn == ttt_pkg::PLAYER_1) ? ttt_pkg::PLAYER_2 : ttt_pkg::PLAYER_1;
			else if (board_full)
				winner <= ttt_pkg::RESULT_TIE;
		end
	end

endmodule

//--- hw/status_display.sv
// seven-segment status digits

`timescale 1ns/10ps

module status_display (
	input  ttt_pkg::square_t   square,
	input  ttt_pkg::tile_t     tile,
	input  ttt_pkg::player_t   turn,
	input  ttt_pkg::player_t   winner,
	output ttt_pkg::seg_t      hex_square,
	output ttt_pkg::seg_t      hex_tile,
	output ttt_pkg::seg_t      hex_turn,
	output ttt_pkg::seg_t      hex_winner
);

	// plain hex digit, 0..F, active low
	function automatic ttt_pkg::seg_t hex_digit(input logic [3:0] value);
		ttt_pkg::seg_t seg;
		case (value)
			4'h0: seg = 7'b1000000;
			4'h1: seg = 7'b1111001;
			4'h2: seg = 7'b0100100;
			4'h3: seg = 7'b0110000;
			4'h4: seg = 7'b0011001;
			4'h5: seg = 7'b0010010;
			4'h6: seg = 7'b0000010;
			4'h7: seg = 7'b1111000;
			4'h8: seg = 7'b0000000;
			4'h9: seg = 7'b0011000;
			4'hA: seg = 7'b0001000;
			4'hB: seg = 7'b0000011;
			4'hC: seg = 7'b1000110;
			4'hD: seg = 7'b0100001;
			4'hE: seg = 7'b0000110;
			default: seg = 7'b0001110;
		endcase
		return seg;
	endfunction

	// selected square straight off the switches
	assign hex_square = hex_digit(square);

	// turn and result are 2-bit codes, 3 shows a tie
	assign hex_turn = hex_digit({2'b00, turn});
	assign hex_winner = hex_digit({2'b00, winner});

	// selected tile glyph
	always_comb
	begin
		case (tile)
			ttt_pkg::TILE_X: hex_tile = ttt_pkg::SEG_TILE_X;
			ttt_pkg::TILE_O: hex_tile = ttt_pkg::SEG_TILE_O;
			// empty or 11 shows just the bar
			default: hex_tile = ttt_pkg::SEG_BLANK_DASH;
		endcase
	end

endmodule

//--- hw/tictactoe_top.sv
// wild misere tic-tac-toe top level

`timescale 1ns/10ps

module tictactoe_top (
	input  logic               clock,
	input  logic               resetn,
	input  logic               go,
	input  ttt_pkg::square_t   square,
	input  ttt_pkg::tile_t     tile,
	output ttt_pkg::player_t   turn,
	output ttt_pkg::player_t   winner,
	output logic               game_over,
	output ttt_pkg::seg_t      hex_square,
	output ttt_pkg::seg_t      hex_tile,
	output ttt_pkg::seg_t      hex_turn,
	output ttt_pkg::seg_t      hex_winner
);

	// FSM to datapath strobes
	logic load_square;
	logic load_tile;
	logic check_done;

	// end check back to FSM
	logic line_made;
	logic board_full;

	// square 1 in the low slot
	ttt_pkg::tile_t [ttt_pkg::NUM_SQUARES-1:0] board;

	turn_control u_turn_control (
		.clock       (clock),
		.resetn      (resetn),
		.go          (go),
		.line_made   (line_made),
		.board_full  (board_full),
		.load_square (load_square),
		.load_tile   (load_tile),
		.check_done  (check_done),
		.turn        (turn)
	);

	board_store u_board_store (
		.clock       (clock),
		.resetn      (resetn),
		.load_square (load_square),
		.load_tile   (load_tile),
		.square      (square),
		.tile        (tile),
		.board       (board)
	);

	end_check u_end_check (
		.clock       (clock),
		.resetn      (resetn),
		.board       (board),
		.turn        (turn),
		.check_done  (check_done),
		.line_made   (line_made),
		.board_full  (board_full),
		.game_over   (game_over),
		.winner      (winner)
	);

	// digits show the live switch values, not the latched ones
	status_display u_status_display (
		.square      (square),
		.tile        (tile),
		.turn        (turn),
		.winner      (winner),
		.hex_square  (hex_square),
		.hex_tile    (hex_tile),
		.hex_turn    (hex_turn),
		.hex_winner  (hex_winner)
	);

endmodule

//--- sim/tb_game_tasks.svh
// testbench helpers
// commit pulses and digit tables

// one go pulse for a square, value held while go is high
task automatic commit_square(input int value);
	@(negedge clock);
	square = ttt_pkg::square_t'(value);
	go = 1'b1;
	@(negedge clock);
	go = 1'b0;
endtask

// same pulse for a tile
task automatic commit_tile(input int value);
	@(negedge clock);
	tile = ttt_pkg::tile_t'(value);
	go = 1'b1;
	@(negedge clock);
	go = 1'b0;
endtask

// active low digits, bit 6 is segment g
function automatic int digit_seg(input int value);
	case (value)
		0: return 7'b1000000;
		1: return 7'b1111001;
		2: return 7'b0100100;
		3: return 7'b0110000;
		4: return 7'b0011001;
		5: return 7'b0010010;
		6: return 7'b0000010;
		7: return 7'b1111000;
		8: return 7'b0000000;
		9: return 7'b0011000;
		default: return 7'b1111111;
	endcase
endfunction

// tile glyphs, X as H and O as 0
function automatic int tile_seg(input int value);
	case (value)
		1: return 7'b0001001;
		2: return 7'b1000000;
		// empty and 11 only light the bar
		default: return 7'b0111111;
	endcase
endfunction

//--- sim/tictactoe_tb.sv
// testbench for wild misere tic-tac-toe
`timescale 1ns/10ps

module tictactoe_tb;

	localparam int TIMEOUT_CYCLES = 20;

	logic clock;
	logic resetn;
	logic go;
	ttt_pkg::square_t square;
	ttt_pkg::tile_t tile;
	ttt_pkg::player_t turn;
	ttt_pkg::player_t winner;
	logic game_over;
	ttt_pkg::seg_t hex_square;
	ttt_pkg::seg_t hex_tile;
	ttt_pkg::seg_t hex_turn;
	ttt_pkg::seg_t hex_winner;

	int mismatches;
	int timeouts;
	// player expected to move next
	int mover;
	int unsigned lcg_state;
	// reference board, index is the square number, 0 empty 1 X 2 O
	int model [1:9];
	int order [1:9];
	// full tiling with no line of three
	int tie_tile [1:9] = '{1, 2, 1, 1, 2, 2, 2, 1, 1};
	// rows, columns, diagonals
	int lines [0:7][0:2] = '{'{1, 2, 3}, '{4, 5, 6}, '{7, 8, 9}, '{1, 4, 7},
		'{2, 5, 8}, '{3, 6, 9}, '{1, 5, 9}, '{3, 5, 7}};

	tictactoe_top u_dut (
		.clock      (clock),
		.resetn     (resetn),
		.go         (go),
		.square     (square),
		.tile       (tile),
		.turn       (turn),
		.winner     (winner),
		.game_over  (game_over),
		.hex_square (hex_square),
		.hex_tile   (hex_tile),
		.hex_turn   (hex_turn),
		.hex_winner (hex_winner)
	);

	`include "tb_game_tasks.svh"

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	task automatic check_value(input string name, input int expected, input int actual);
		assert (expected == actual)
		else
		begin
			mismatches++;
			$display("Mismatch %s: expected %0h actual %0h", name, expected, actual);
		end
	endtask

	function automatic int other_player(input int p);
		return (p == 1) ? 2 : 1;
	endfunction

	// fixed seed LCG
	function automatic int unsigned next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	// three equal non-empty tiles anywhere on the model
	function automatic bit model_has_line();
		bit found;
		found = 1'b0;
		for (int i = 0; i < 8; i++)
		begin
			if (model[lines[i][0]] != 0 && model[lines[i][0]] == model[lines[i][1]]
				&& model[lines[i][1]] == model[lines[i][2]])
				found = 1'b1;
		end
		return found;
	endfunction

	function automatic bit model_full();
		bit full;
		full = 1'b1;
		for (int i = 1; i <= 9; i++)
		begin
			if (model[i] == 0)
				full = 1'b0;
		end
		return full;
	endfunction

	task automatic wait_turn(input int expected, input string name);
		bit seen;
		seen = 1'b0;
		for (int i = 0; i < TIMEOUT_CYCLES && !seen; i++)
		begin
			@(negedge clock);
			seen = (int'(turn) == expected);
		end
		if (!seen)
		begin
			timeouts++;
			$display("Timeout in %s: turn never became %0d", name, expected);
		end
	endtask

	task automatic wait_game_over(input string name);
		bit seen;
		seen = 1'b0;
		for (int i = 0; i < TIMEOUT_CYCLES && !seen; i++)
		begin
			@(negedge clock);
			seen = game_over;
		end
		if (!seen)
		begin
			timeouts++;
			$display("Timeout in %s: game_over never went high", name);
		end
	endtask

	// hold reset low for 3 cycles and clear the model
	task automatic do_reset();
		@(negedge clock);
		resetn = 1'b0;
		go = 1'b0;
		repeat (3) @(negedge clock);
		resetn = 1'b1;
		mover = 1;
		for (int i = 1; i <= 9; i++)
			model[i] = 0;
	endtask

	task automatic check_reset_state(input string name);
		@(negedge clock);
		check_value({name, " turn"}, 1, int'(turn));
		check_value({name, " game_over"}, 0, int'(game_over));
		check_value({name, " winner"}, 0, int'(winner));
		check_value({name, " hex_turn"}, digit_seg(1), int'(hex_turn));
		check_value({name, " hex_winner"}, digit_seg(0), int'(hex_winner));
	endtask

	// predict the outcome from the model, then compare
	task automatic check_after_move(input string name);
		bit exp_line;
		bit exp_full;
		int exp_winner;
		exp_line = model_has_line();
		exp_full = model_full();
		if (exp_line || exp_full)
		begin
			// misere, the mover's own line hands the game over
			exp_winner = exp_line ? other_player(mover) : 3;
			wait_game_over(name);
			check_value({name, " winner"}, exp_winner, int'(winner));
			check_value({name, " hex_winner"}, digit_seg(exp_winner), int'(hex_winner));
		end
		else
		begin
			wait_turn(other_player(mover), name);
			check_value({name, " turn"}, other_player(mover), int'(turn));
			check_value({name, " game_over"}, 0, int'(game_over));
			check_value({name, " hex_turn"}, digit_seg(other_player(mover)), int'(hex_turn));
			check_value({name, " hex_square"}, digit_seg(int'(square)), int'(hex_square));
			mover = other_player(mover);
		end
	endtask

	task automatic play_move(input string name, input int sq, input int t);
		wait_turn(mover, name);
		commit_square(sq);
		commit_tile(t);
		model[sq] = t;
		check_after_move(name);
	endtask

	initial
	begin
		int j;
		int tmp;
		ttt_pkg::player_t held_turn;
		ttt_pkg::player_t held_winner;
		mismatches = 0;
		timeouts = 0;
		mover = 1;
		lcg_state = 65;
		resetn = 1'b0;
		go = 1'b0;
		square = '0;
		tile = '0;
		do_reset();
		check_reset_state("reset");

		// tile digit follows the switches
		for (int t = 0; t < 4; t++)
		begin
			@(negedge clock);
			tile = ttt_pkg::tile_t'(t);
			@(negedge clock);
			check_value("hex_tile", tile_seg(t), int'(hex_tile));
		end

		// player 1 closes the top row with X
		play_move("row loss", 1, 1);
		play_move("row loss", 5, 2);
		play_move("row loss", 2, 1);
		play_move("row loss", 9, 2);
		play_move("row loss", 3, 1);
		check_value("row loss result", 2, int'(winner));

		// go pulses in the end state change nothing
		held_turn = turn;
		held_winner = winner;
		commit_square(4);
		commit_tile(2);
		commit_square(7);
		commit_tile(1);
		@(negedge clock);
		check_value("held turn", int'(held_turn), int'(turn));
		check_value("held winner", int'(held_winner), int'(winner));
		check_value("held game_over", 1, int'(game_over));
		do_reset();
		check_reset_state("second reset");

		// mixed top row, then player 2 closes 3-5-7 with O
		play_move("diagonal loss", 1, 1);
		play_move("diagonal loss", 2, 1);
		play_move("diagonal loss", 3, 2);
		play_move("diagonal loss", 5, 2);
		play_move("diagonal loss", 9, 1);
		play_move("diagonal loss", 7, 2);
		check_value("diagonal loss result", 1, int'(winner));

		// shuffled fill of a board with no line
		do_reset();
		for (int i = 1; i <= 9; i++)
			order[i] = i;
		for (int i = 9; i > 1; i--)
		begin
			j = int'(next_random() % i) + 1;
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (int i = 1; i <= 9; i++)
			play_move("tie fill", order[i], tie_tile[order[i]]);
		check_value("tie result", 3, int'(winner));

		$display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- tictactoe_top.f
hw/ttt_pkg.sv
hw/turn_control.sv
hw/board_store.sv
hw/end_check.sv
hw/status_display.sv
hw/tictactoe_top.sv
+incdir+sim
sim/tictactoe_tb.sv

//--- Makefile
# Verilator build and run for the tic-tac-toe testbench

VERILATOR ?= verilator
TOP ?= tictactoe_tb
FILELIST ?= tictactoe_top.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= Done: no errors

SIM = $(BUILD_DIR)/V$(TOP)
SOURCES = $(wildcard hw/*.sv) $(wildcard sim/*.sv) $(wildcard sim/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# fails unless the pass message shows up on its own line
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
